/* Makefile */
# Verilator build and run of the riscv_pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_pipeline
FILELIST  ?= riscv_pipeline.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* hdl/control.sv */
// Instruction decoder, control pipeline, hazard detection
// and bypass selects
`timescale 1ns/1ns
module control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  riscv_pkg::if_id_t    if_id,
	input  logic                 br_true,
	input  riscv_pkg::id_ex_t    id_ex,
	input  riscv_pkg::ex_mem_t   ex_mem,
	input  riscv_pkg::mem_wb_t   wb,
	output riscv_pkg::pc_sel_e   pc_sel,
	output riscv_pkg::imm_sel_e  imm_sel,
	output logic [2:0]           br_op,
	output riscv_pkg::ctrl_ex_t  ctrl_ex,
	output riscv_pkg::ctrl_mem_t ctrl_mem,
	output riscv_pkg::ctrl_wb_t  ctrl_wb,
	output logic                 reg_en,
	output logic                 stall_if,
	output logic                 flush_if,
	output logic                 stall_id,
	output logic                 flush_id,
	output riscv_pkg::fwd_sel_e  branch_a_sel,
	output riscv_pkg::fwd_sel_e  branch_b_sel,
	output riscv_pkg::fwd_sel_e  forward_a_sel,
	output riscv_pkg::fwd_sel_e  forward_b_sel
);
	import riscv_pkg::*;

	rv_instr_u instr;
	ctrl_ex_t dec_ex;
	ctrl_mem_t dec_mem;
	ctrl_wb_t dec_wb;
	// MEM and WB bundles while the instruction sits in EX
	ctrl_mem_t mem_in_ex;
	ctrl_wb_t wb_in_ex;
	logic uses_rs1;
	logic uses_rs2;
	logic is_branch;
	logic is_jal;
	logic is_jalr;
	logic no_effect;
	logic ex_hit1;
	logic ex_hit2;
	logic mem_hit1;
	logic mem_hit2;
	logic wb_hit1;
	logic wb_hit2;
	logic load_use;
	logic br_dep;
	logic hazard;

	assign instr = if_id.instr;
	assign br_op = instr.b.funct3;

	function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic alt,
			input logic is_reg);
		case (funct3)
			3'b000:  alu_decode = (is_reg && alt) ? ALU_SUB : ALU_ADD;
			3'b001:  alu_decode = ALU_SLL;
			3'b010:  alu_decode = ALU_SLT;
			3'b011:  alu_decode = ALU_SLTU;
			3'b100:  alu_decode = ALU_XOR;
			3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_decode = ALU_OR;
			default: alu_decode = ALU_AND;
		endcase
	endfunction

	// Producer match; x0 is never a bypass source
	function automatic logic hit(input logic [REG_ADDR_W-1:0] rs,
			input logic [REG_ADDR_W-1:0] rd, input logic wr_en, input logic used);
		hit = used && wr_en && (rd != '0) && (rs == rd);
	endfunction

	always_comb begin
		dec_ex    = '{a_sel: A_REG, b_sel: B_IMM, alu_op: ALU_ADD};
		dec_mem   = '0;
		dec_wb    = '{wb_sel: WB_ALU, reg_en: 1'b0};
		imm_sel   = IMM_I;
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		no_effect = 1'b0;
		case (instr.r.opcode)
			OP_LUI: begin
				imm_sel       = IMM_U;
				dec_ex.alu_op = ALU_COPY_B;
				dec_wb.reg_en = 1'b1;
			end
			OP_AUIPC: begin
				imm_sel       = IMM_U;
				dec_ex.a_sel  = A_PC;
				dec_wb.reg_en = 1'b1;
			end
			OP_JAL: begin
				imm_sel = IMM_J;
				dec_ex  = '{a_sel: A_PC, b_sel: B_IMM, alu_op: ALU_LINK};
				dec_wb  = '{wb_sel: WB_PC4, reg_en: 1'b1};
				is_jal  = 1'b1;
			end
			OP_JALR: begin
				dec_ex   = '{a_sel: A_PC, b_sel: B_IMM, alu_op: ALU_LINK};
				dec_wb   = '{wb_sel: WB_PC4, reg_en: 1'b1};
				uses_rs1 = 1'b1;
				is_jalr  = 1'b1;
			end
			OP_BRANCH: begin
				imm_sel   = IMM_B;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				is_branch = 1'b1;
				// Fully resolved here, nothing left for EX
				no_effect = 1'b1;
			end
			OP_LOAD: begin
				uses_rs1       = 1'b1;
				dec_mem.mem_en = 1'b1;
				dec_wb         = '{wb_sel: WB_MEM, reg_en: 1'b1};
			end
			OP_STORE: begin
				imm_sel  = IMM_S;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				dec_mem  = '{mem_wr: 1'b1, mem_en: 1'b1};
			end
			OP_IMM: begin
				uses_rs1      = 1'b1;
				dec_ex.alu_op = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b0);
				dec_wb.reg_en = 1'b1;
			end
			OP_REG: begin
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
				dec_ex.b_sel  = B_REG;
				dec_ex.alu_op = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b1);
				dec_wb.reg_en = 1'b1;
			end
			// FENCE, SYSTEM and unknown opcodes
			default: no_effect = 1'b1;
		endcase
	end

	// ID sources against producers in EX, MEM and WB
	assign ex_hit1  = hit(instr.r.rs1, id_ex.rd_addr, wb_in_ex.reg_en, uses_rs1);
	assign ex_hit2  = hit(instr.r.rs2, id_ex.rd_addr, wb_in_ex.reg_en, uses_rs2);
	assign mem_hit1 = hit(instr.r.rs1, ex_mem.rd_addr, ctrl_wb.reg_en, uses_rs1);
	assign mem_hit2 = hit(instr.r.rs2, ex_mem.rd_addr, ctrl_wb.reg_en, uses_rs2);
	assign wb_hit1  = hit(instr.r.rs1, wb.rd_addr, reg_en, uses_rs1);
	assign wb_hit2  = hit(instr.r.rs2, wb.rd_addr, reg_en, uses_rs2);

	assign load_use = (wb_in_ex.wb_sel == WB_MEM) && (ex_hit1 || ex_hit2);
	// Branch compare needs the value by ID, a load in MEM is still too late
	assign br_dep = (is_branch || is_jalr) && (ex_hit1 || ex_hit2 ||
		((ctrl_wb.wb_sel == WB_MEM) && (mem_hit1 || mem_hit2)));
	assign hazard = load_use || br_dep;

	assign stall_if = hazard;
	assign stall_id = hazard;
	assign flush_id = no_effect;

	always_comb begin
		pc_sel = PC_PLUS4;
		if (!hazard) begin
			if (is_jal)
				pc_sel = PC_JAL;
			else if (is_jalr)
				pc_sel = PC_JALR;
			else if (is_branch && br_true)
				pc_sel = PC_BR;
		end
	end

	assign flush_if = (pc_sel != PC_PLUS4);

	assign branch_a_sel = mem_hit1 ? FWD_MEM : (wb_hit1 ? FWD_WB : FWD_RF);
	assign branch_b_sel = mem_hit2 ? FWD_MEM : (wb_hit2 ? FWD_WB : FWD_RF);

	// EX operand bypass, nearest producer first
	assign forward_a_sel = hit(id_ex.rs1_addr, ex_mem.rd_addr, ctrl_wb.reg_en, 1'b1) ?
		FWD_MEM : (hit(id_ex.rs1_addr, wb.rd_addr, reg_en, 1'b1) ? FWD_WB : FWD_RF);
	assign forward_b_sel = hit(id_ex.rs2_addr, ex_mem.rd_addr, ctrl_wb.reg_en, 1'b1) ?
		FWD_MEM : (hit(id_ex.rs2_addr, wb.rd_addr, reg_en, 1'b1) ? FWD_WB : FWD_RF);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_ex   <= '0;
			mem_in_ex <= '0;
			wb_in_ex  <= '0;
			ctrl_mem  <= '0;
			ctrl_wb   <= '0;
			reg_en    <= 1'b0;
		end else begin
			if (hazard || no_effect) begin
				ctrl_ex   <= '0;
				mem_in_ex <= '0;
				wb_in_ex  <= '0;
			end else begin
				ctrl_ex   <= dec_ex;
				mem_in_ex <= dec_mem;
				wb_in_ex  <= dec_wb;
			end
			ctrl_mem <= mem_in_ex;
			ctrl_wb  <= wb_in_ex;
			reg_en   <= ctrl_wb.reg_en;
		end
	end

endmodule

/* hdl/decode.sv */
// Register file, immediate generation, branch resolution
// and the ID/EX register
`timescale 1ns/1ns
module decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  riscv_pkg::if_id_t          if_id,
	input  riscv_pkg::mem_wb_t         wb,
	input  logic                       reg_en,
	input  riscv_pkg::imm_sel_e        imm_sel,
	input  logic [2:0]                 br_op,
	input  riscv_pkg::fwd_sel_e        branch_a_sel,
	input  riscv_pkg::fwd_sel_e        branch_b_sel,
	input  logic [riscv_pkg::XLEN-1:0] fwd_mem,
	input  logic                       stall_id,
	input  logic                       flush_id,
	output riscv_pkg::id_ex_t          id_ex,
	output logic                       br_true,
	output logic [riscv_pkg::XLEN-1:0] br_target,
	output logic [riscv_pkg::XLEN-1:0] jal_target,
	output logic [riscv_pkg::XLEN-1:0] jalr_target
);
	import riscv_pkg::*;

	localparam id_ex_t ID_EX_NOP = '{instr: NOP_INSTR, default: '0};

	// x0 is hardwired, so no storage for it
	logic [XLEN-1:0] regs [1:31];
	rv_instr_u instr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] br_a;
	logic [XLEN-1:0] br_b;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] jalr_sum;

	assign instr = if_id.instr;

	// Read port with write-through from the WB stage
	function automatic logic [XLEN-1:0] rf_read(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			rf_read = '0;
		else if (reg_en && wb.rd_addr == addr)
			rf_read = wb.data;
		else
			rf_read = regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reg_en && wb.rd_addr != '0)
			regs[wb.rd_addr] <= wb.data;
	end

	assign rs1_data = rf_read(instr.r.rs1);
	assign rs2_data = rf_read(instr.r.rs2);

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
		instr.b.imm10_5, instr.b.imm4_1, 1'b0};
	assign imm_u = {instr.u.imm, 12'b0};
	assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
		instr.j.imm11, instr.j.imm10_1, 1'b0};

	always_comb begin
		case (imm_sel)
			IMM_S:   imm = imm_s;
			IMM_B:   imm = imm_b;
			IMM_U:   imm = imm_u;
			IMM_J:   imm = imm_j;
			default: imm = imm_i;
		endcase
	end

	// Branch operands may come from instructions still in flight
	assign br_a = fwd_pick(branch_a_sel, rs1_data, fwd_mem, wb.data);
	assign br_b = fwd_pick(branch_b_sel, rs2_data, fwd_mem, wb.data);

	always_comb begin
		case (br_op)
			3'b000:  br_true = (br_a == br_b);
			3'b001:  br_true = (br_a != br_b);
			3'b100:  br_true = ($signed(br_a) < $signed(br_b));
			3'b101:  br_true = ($signed(br_a) >= $signed(br_b));
			3'b110:  br_true = (br_a < br_b);
			3'b111:  br_true = (br_a >= br_b);
			default: br_true = 1'b0;
		endcase
	end

	assign br_target   = if_id.pc + imm_b;
	assign jal_target  = if_id.pc + imm_j;
	assign jalr_sum    = br_a + imm_i;
	assign jalr_target = {jalr_sum[XLEN-1:1], 1'b0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= ID_EX_NOP;
		end else if (stall_id || flush_id) begin
			// Bubble into EX
			id_ex <= ID_EX_NOP;
		end else begin
			id_ex.pc       <= if_id.pc;
			id_ex.instr    <= instr;
			id_ex.rs1_data <= rs1_data;
			id_ex.rs2_data <= rs2_data;
			id_ex.imm      <= imm;
			id_ex.rs1_addr <= instr.r.rs1;
			id_ex.rs2_addr <= instr.r.rs2;
			id_ex.rd_addr  <= instr.r.rd;
		end
	end

endmodule

/* hdl/execute.sv */
// Operand bypass, ALU and the EX/MEM register
`timescale 1ns/1ns
module execute (
	input  logic                       clk,
	input  logic                       rst_n,
	input  riscv_pkg::id_ex_t          id_ex,
	input  riscv_pkg::ctrl_ex_t        ctrl_ex,
	input  riscv_pkg::fwd_sel_e        forward_a_sel,
	input  riscv_pkg::fwd_sel_e        forward_b_sel,
	input  logic [riscv_pkg::XLEN-1:0] fwd_wb,
	output riscv_pkg::ex_mem_t         ex_mem
);
	import riscv_pkg::*;

	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	logic [4:0] shamt;

	// EX/MEM bypass comes straight from our own output register
	assign rs1_val = fwd_pick(forward_a_sel, id_ex.rs1_data, ex_mem.alu, fwd_wb);
	assign rs2_val = fwd_pick(forward_b_sel, id_ex.rs2_data, ex_mem.alu, fwd_wb);

	assign op_a  = (ctrl_ex.a_sel == A_PC) ? id_ex.pc : rs1_val;
	assign op_b  = (ctrl_ex.b_sel == B_IMM) ? id_ex.imm : rs2_val;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl_ex.alu_op)
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << shamt;
			ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> shamt;
			ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_COPY_B: alu_out = op_b;
			// Link value, so a jump's rd can be bypassed like any ALU result
			ALU_LINK:   alu_out = op_a + 32'd4;
			default:    alu_out = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.pc4        <= id_ex.pc + 32'd4;
			ex_mem.alu        <= alu_out;
			ex_mem.store_data <= rs2_val;
			ex_mem.rd_addr    <= id_ex.rd_addr;
		end
	end

endmodule

/* hdl/fetch.sv */
// Program counter, next-PC mux and the IF/ID register
`timescale 1ns/1ns
module fetch #(
	parameter int IMEM_ADDR_W = riscv_pkg::IMEM_ADDR_W_DEF
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  riscv_pkg::pc_sel_e         pc_sel,
	input  logic [riscv_pkg::XLEN-1:0] br_target,
	input  logic [riscv_pkg::XLEN-1:0] jal_target,
	input  logic [riscv_pkg::XLEN-1:0] jalr_target,
	input  logic                       stall_if,
	input  logic                       flush_if,
	input  logic [riscv_pkg::XLEN-1:0] instr_imem,
	output logic [IMEM_ADDR_W-1:0]     pc_imem,
	output riscv_pkg::if_id_t          if_id
);
	import riscv_pkg::*;

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_next;

	// Instruction memory is word addressed
	assign pc_imem = pc[IMEM_ADDR_W+1:2];

	always_comb begin
		case (pc_sel)
			PC_BR:   pc_next = br_target;
			PC_JAL:  pc_next = jal_target;
			PC_JALR: pc_next = jalr_target;
			default: pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc          <= '0;
			if_id.pc    <= '0;
			if_id.instr <= NOP_INSTR;
		end else if (!stall_if) begin
			pc       <= pc_next;
			if_id.pc <= pc;
			// Wrong-path instruction behind a taken redirect
			if (flush_if)
				if_id.instr <= NOP_INSTR;
			else
				if_id.instr <= instr_imem;
		end
	end

endmodule

/* hdl/mem_stage.sv */
// Data memory request, writeback select and the MEM/WB register
`timescale 1ns/1ns
module mem_stage #(
	parameter int DMEM_ADDR_W = riscv_pkg::DMEM_ADDR_W_DEF
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  riscv_pkg::ex_mem_t         ex_mem,
	input  riscv_pkg::ctrl_mem_t       ctrl_mem,
	input  riscv_pkg::ctrl_wb_t        ctrl_wb,
	input  logic [riscv_pkg::XLEN-1:0] dmem_rdata,
	output riscv_pkg::dmem_req_t       dmem_req,
	output riscv_pkg::mem_wb_t         wb
);
	import riscv_pkg::*;

	logic [XLEN-1:0] wb_data;

	// Word accesses only, byte offset dropped
	assign dmem_req.addr  = {{(XLEN-DMEM_ADDR_W){1'b0}}, ex_mem.alu[DMEM_ADDR_W+1:2]};
	assign dmem_req.wdata = ex_mem.store_data;
	assign dmem_req.wr    = ctrl_mem.mem_wr;
	assign dmem_req.en    = ctrl_mem.mem_en;

	always_comb begin
		case (ctrl_wb.wb_sel)
			WB_MEM:  wb_data = dmem_rdata;
			WB_PC4:  wb_data = ex_mem.pc4;
			default: wb_data = ex_mem.alu;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.data <= wb_data;
			// No write means rd reads as x0 downstream
			wb.rd_addr <= ctrl_wb.reg_en ? ex_mem.rd_addr : '0;
		end
	end

endmodule

/* hdl/riscv_pipeline.sv */
// Five-stage RV32I core top level with instruction and data memory ports
`timescale 1ns/1ns
module riscv_pipeline #(
	parameter int IMEM_ADDR_W = riscv_pkg::IMEM_ADDR_W_DEF,
	parameter int DMEM_ADDR_W = riscv_pkg::DMEM_ADDR_W_DEF
) (
	input  logic                       clk,
	input  logic                       rst_n,
	output logic [IMEM_ADDR_W-1:0]     pc_imem,
	input  logic [riscv_pkg::XLEN-1:0] instr_imem,
	output riscv_pkg::dmem_req_t       dmem_req,
	input  logic [riscv_pkg::XLEN-1:0] dmem_rdata
);
	import riscv_pkg::*;

	// Stage registers
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t wb;

	// Redirects resolved in ID
	logic br_true;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] jal_target;
	logic [XLEN-1:0] jalr_target;

	pc_sel_e pc_sel;
	imm_sel_e imm_sel;
	logic [2:0] br_op;
	ctrl_ex_t ctrl_ex;
	ctrl_mem_t ctrl_mem;
	ctrl_wb_t ctrl_wb;
	logic reg_en;

	logic stall_if;
	logic flush_if;
	logic stall_id;
	logic flush_id;
	fwd_sel_e branch_a_sel;
	fwd_sel_e branch_b_sel;
	fwd_sel_e forward_a_sel;
	fwd_sel_e forward_b_sel;

	fetch #(
		.IMEM_ADDR_W(IMEM_ADDR_W)
	) fetch_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pc_sel(pc_sel),
		.br_target(br_target),
		.jal_target(jal_target),
		.jalr_target(jalr_target),
		.stall_if(stall_if),
		.flush_if(flush_if),
		.instr_imem(instr_imem),
		.pc_imem(pc_imem),
		.if_id(if_id)
	);

	decode decode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.if_id(if_id),
		.wb(wb),
		.reg_en(reg_en),
		.imm_sel(imm_sel),
		.br_op(br_op),
		.branch_a_sel(branch_a_sel),
		.branch_b_sel(branch_b_sel),
		.fwd_mem(ex_mem.alu),
		.stall_id(stall_id),
		.flush_id(flush_id),
		.id_ex(id_ex),
		.br_true(br_true),
		.br_target(br_target),
		.jal_target(jal_target),
		.jalr_target(jalr_target)
	);

	execute execute_inst (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex),
		.ctrl_ex(ctrl_ex),
		.forward_a_sel(forward_a_sel),
		.forward_b_sel(forward_b_sel),
		.fwd_wb(wb.data),
		.ex_mem(ex_mem)
	);

	mem_stage #(
		.DMEM_ADDR_W(DMEM_ADDR_W)
	) mem_stage_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem),
		.ctrl_mem(ctrl_mem),
		.ctrl_wb(ctrl_wb),
		.dmem_rdata(dmem_rdata),
		.dmem_req(dmem_req),
		.wb(wb)
	);

	control control_inst (
		.clk(clk),
		.rst_n(rst_n),
		.if_id(if_id),
		.br_true(br_true),
		.id_ex(id_ex),
		.ex_mem(ex_mem),
		.wb(wb),
		.pc_sel(pc_sel),
		.imm_sel(imm_sel),
		.br_op(br_op),
		.ctrl_ex(ctrl_ex),
		.ctrl_mem(ctrl_mem),
		.ctrl_wb(ctrl_wb),
		.reg_en(reg_en),
		.stall_if(stall_if),
		.flush_if(flush_if),
		.stall_id(stall_id),
		.flush_id(flush_id),
		.branch_a_sel(branch_a_sel),
		.branch_b_sel(branch_b_sel),
		.forward_a_sel(forward_a_sel),
		.forward_b_sel(forward_b_sel)
	);

endmodule

/* hdl/riscv_pkg.sv */
// Widths, encodings, instruction formats and pipeline bundles
// shared by every stage of the RV32I core
package riscv_pkg;

	parameter int XLEN            = 32;
	parameter int REG_ADDR_W      = 5;
	parameter int IMEM_ADDR_W_DEF = 10;
	parameter int DMEM_ADDR_W_DEF = 10;

	// ADDI x0, x0, 0
	parameter logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B, ALU_LINK
	} alu_op_e;

	typedef enum logic {A_REG, A_PC} a_sel_e;
	typedef enum logic {B_REG, B_IMM} b_sel_e;
	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
	typedef enum logic [1:0] {PC_PLUS4, PC_BR, PC_JAL, PC_JALR} pc_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
	typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [REG_ADDR_W-1:0] rd;
		opcode_e opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [REG_ADDR_W-1:0] rd;
		opcode_e opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		opcode_e opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [REG_ADDR_W-1:0] rd;
		opcode_e opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [REG_ADDR_W-1:0] rd;
		opcode_e opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_instr_u;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		rv_instr_u instr;
	} if_id_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		rv_instr_u instr;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] imm;
		logic [REG_ADDR_W-1:0] rs1_addr;
		logic [REG_ADDR_W-1:0] rs2_addr;
		logic [REG_ADDR_W-1:0] rd_addr;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] pc4;
		logic [XLEN-1:0] alu;
		logic [XLEN-1:0] store_data;
		logic [REG_ADDR_W-1:0] rd_addr;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0] data;
		logic [REG_ADDR_W-1:0] rd_addr;
	} mem_wb_t;

	typedef struct packed {
		a_sel_e a_sel;
		b_sel_e b_sel;
		alu_op_e alu_op;
	} ctrl_ex_t;

	typedef struct packed {
		logic mem_wr;
		logic mem_en;
	} ctrl_mem_t;

	typedef struct packed {
		wb_sel_e wb_sel;
		logic reg_en;
	} ctrl_wb_t;

	// addr is a word address into data memory
	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		logic wr;
		logic en;
	} dmem_req_t;

	// Operand bypass mux, used for branches in ID and the ALU in EX
	function automatic logic [XLEN-1:0] fwd_pick(input fwd_sel_e sel,
			input logic [XLEN-1:0] rf_val, input logic [XLEN-1:0] mem_val,
			input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: fwd_pick = mem_val;
			FWD_WB:  fwd_pick = wb_val;
			default: fwd_pick = rf_val;
		endcase
	endfunction

endpackage

/* riscv_pipeline.f */
hdl/riscv_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem_stage.sv
hdl/control.sv
hdl/riscv_pipeline.sv
verification/tb_memory_model.sv
verification/tb_riscv_pipeline.sv

/* verification/riscv_stimulus.txt */
# P <word index> <instruction>   program word for instruction memory
# S <word address> <data>        expected data-memory store, in order
P 000 00500093  addi x1, x0, 5
P 001 ffd00113  addi x2, x0, -3
P 002 002081b3  add  x3, x1, x2
P 003 40118233  sub  x4, x3, x1
P 004 10402023  sw   x4, 0x100(x0)
P 005 001122b3  slt  x5, x2, x1
P 006 00113333  sltu x6, x2, x1
P 007 001093b3  sll  x7, x1, x1
P 008 40115433  sra  x8, x2, x1
P 009 001154b3  srl  x9, x2, x1
P 00a 0020c533  xor  x10, x1, x2
P 00b 0013e5b3  or   x11, x7, x1
P 00c 00b57633  and  x12, x10, x11
P 00d 10502223  sw   x5, 0x104(x0)
P 00e 10602423  sw   x6, 0x108(x0)
P 00f 10702623  sw   x7, 0x10c(x0)
P 010 10802823  sw   x8, 0x110(x0)
P 011 10902a23  sw   x9, 0x114(x0)
P 012 10a02c23  sw   x10, 0x118(x0)
P 013 10b02e23  sw   x11, 0x11c(x0)
P 014 12c02023  sw   x12, 0x120(x0)
P 015 ffe12693  slti x13, x2, -2
P 016 7ff0c713  xori x14, x1, 0x7ff
P 017 40115793  srai x15, x2, 1
P 018 12345837  lui  x16, 0x12345
P 019 00001897  auipc x17, 1
P 01a 67886913  ori  x18, x16, 0x678
P 01b 12d02223  sw   x13, 0x124(x0)
P 01c 12e02423  sw   x14, 0x128(x0)
P 01d 12f02623  sw   x15, 0x12c(x0)
P 01e 13102823  sw   x17, 0x130(x0)
P 01f 13202a23  sw   x18, 0x134(x0)
P 020 00708013  addi x0, x1, 7
P 021 12002c23  sw   x0, 0x138(x0)
P 022 10002a03  lw   x20, 0x100(x0)
P 023 001a0ab3  add  x21, x20, x1
P 024 13502e23  sw   x21, 0x13c(x0)
P 025 00000b13  addi x22, x0, 0
P 026 00500b93  addi x23, x0, 5
P 027 001b8463  beq  x23, x1, +8   taken
P 028 1e002823  sw   x0, 0x1f0(x0) skipped
P 029 00209463  bne  x1, x2, +8    taken
P 02a 1e002823  sw   x0, 0x1f0(x0) skipped
P 02b 00114463  blt  x2, x1, +8    taken
P 02c 1e002823  sw   x0, 0x1f0(x0) skipped
P 02d 0020d463  bge  x1, x2, +8    taken
P 02e 1e002823  sw   x0, 0x1f0(x0) skipped
P 02f 0020e463  bltu x1, x2, +8    taken
P 030 1e002823  sw   x0, 0x1f0(x0) skipped
P 031 10002c03  lw   x24, 0x100(x0)
P 032 001c7463  bgeu x24, x1, +8   taken
P 033 1e002823  sw   x0, 0x1f0(x0) skipped
P 034 00208463  beq  x1, x2, +8    not taken
P 035 001b0b13  addi x22, x22, 1
P 036 01709463  bne  x1, x23, +8   not taken
P 037 001b0b13  addi x22, x22, 1
P 038 0020c463  blt  x1, x2, +8    not taken
P 039 001b0b13  addi x22, x22, 1
P 03a 00115463  bge  x2, x1, +8    not taken
P 03b 001b0b13  addi x22, x22, 1
P 03c 00116463  bltu x2, x1, +8    not taken
P 03d 001b0b13  addi x22, x22, 1
P 03e 0180f463  bgeu x1, x24, +8   not taken
P 03f 001b0b13  addi x22, x22, 1
P 040 15602023  sw   x22, 0x140(x0)
P 041 00c00cef  jal  x25, +12
P 042 1e002823  sw   x0, 0x1f0(x0) skipped
P 043 1e002823  sw   x0, 0x1f0(x0) skipped
P 044 15902223  sw   x25, 0x144(x0)
P 045 11c00d13  addi x26, x0, 0x11c
P 046 004d0de7  jalr x27, 4(x26)
P 047 1e002823  sw   x0, 0x1f0(x0) skipped
P 048 15b02423  sw   x27, 0x148(x0)
P 049 7e102e23  sw   x1, 0x7fc(x0)  end marker
P 04a 0000006f  jal  x0, 0
S 040 fffffffd  sub result
S 041 00000001  slt
S 042 00000000  sltu
S 043 000000a0  sll
S 044 ffffffff  sra
S 045 07ffffff  srl
S 046 fffffff8  xor
S 047 000000a5  or
S 048 000000a0  and
S 049 00000001  slti
S 04a 000007fa  xori
S 04b fffffffe  srai
S 04c 00001064  auipc
S 04d 12345678  lui then ori
S 04e 00000000  x0 stays zero
S 04f 00000002  load-use add
S 050 00000006  not-taken branch count
S 051 00000108  jal link
S 052 0000011c  jalr link
S 1ff 00000005  end marker

/* verification/tb_memory_model.sv */
// Instruction and data memories with combinational read for the testbench
`timescale 1ns/1ns
module tb_memory_model #(
	parameter int IMEM_ADDR_W = riscv_pkg::IMEM_ADDR_W_DEF,
	parameter int DMEM_ADDR_W = riscv_pkg::DMEM_ADDR_W_DEF
) (
	input  logic                       clk,
	input  logic [IMEM_ADDR_W-1:0]     pc_imem,
	output logic [riscv_pkg::XLEN-1:0] instr_imem,
	input  riscv_pkg::dmem_req_t       dmem_req,
	output logic [riscv_pkg::XLEN-1:0] dmem_rdata
);
	import riscv_pkg::*;

	logic [XLEN-1:0] imem [0:(1<<IMEM_ADDR_W)-1];
	logic [XLEN-1:0] dmem [0:(1<<DMEM_ADDR_W)-1];

	initial begin
		// Unloaded words are ADDI x0, x0, <index>
		for (int i = 0; i < (1 << IMEM_ADDR_W); i++)
			imem[i] = {i[11:0], 20'h00013};
		for (int i = 0; i < (1 << DMEM_ADDR_W); i++)
			dmem[i] = 32'hd000_0000 | i;
	end

	assign instr_imem = imem[pc_imem];
	assign dmem_rdata = dmem[dmem_req.addr[DMEM_ADDR_W-1:0]];

	always @(posedge clk) begin
		if (dmem_req.en && dmem_req.wr)
			dmem[dmem_req.addr[DMEM_ADDR_W-1:0]] <= dmem_req.wdata;
	end

endmodule

/* verification/tb_riscv_pipeline.sv */
// Testbench top for the RV32I pipeline with clock, reset, program loading,
// store checking against the expected sequence, watchdog and summary
`timescale 1ns/1ns
module tb_riscv_pipeline;
	import riscv_pkg::*;

	localparam int IMEM_ADDR_W  = IMEM_ADDR_W_DEF;
	localparam int DMEM_ADDR_W  = DMEM_ADDR_W_DEF;
	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	// Word address of the final store that ends the program
	localparam logic [XLEN-1:0] END_ADDR = 32'h0000_01ff;
	localparam string STIM_FILE = "verification/riscv_stimulus.txt";

	logic clk;
	logic rst_n;
	logic [IMEM_ADDR_W-1:0] pc_imem;
	logic [XLEN-1:0] instr_imem;
	dmem_req_t dmem_req;
	logic [XLEN-1:0] dmem_rdata;

	logic [XLEN-1:0] exp_addr_q[$];
	logic [XLEN-1:0] exp_data_q[$];
	int prog_len;
	int error_count;
	int store_count;
	logic loaded;
	logic end_seen;

	riscv_pipeline #(
		.IMEM_ADDR_W(IMEM_ADDR_W),
		.DMEM_ADDR_W(DMEM_ADDR_W)
	) riscv_pipeline_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pc_imem(pc_imem),
		.instr_imem(instr_imem),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata)
	);

	tb_memory_model #(
		.IMEM_ADDR_W(IMEM_ADDR_W),
		.DMEM_ADDR_W(DMEM_ADDR_W)
	) memory_inst (
		.clk(clk),
		.pc_imem(pc_imem),
		.instr_imem(instr_imem),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata)
	);

	// P lines go to instruction memory, S lines to the expected store queue
	task automatic load_stimulus(output bit ok);
		int fd;
		int n;
		string line;
		byte tag;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
		fd = $fopen(STIM_FILE, "r");
		ok = 1'b0;
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%c %h %h", tag, addr, data);
				if (n == 3 && tag == "P") begin
					memory_inst.imem[addr[IMEM_ADDR_W-1:0]] = data;
					prog_len++;
				end else if (n == 3 && tag == "S") begin
					exp_addr_q.push_back(addr);
					exp_data_q.push_back(data);
				end
			end
			$fclose(fd);
			ok = (prog_len > 0) && (exp_addr_q.size() > 0);
		end
	endtask

	task automatic check_store(input logic en, input logic [XLEN-1:0] addr,
			input logic [XLEN-1:0] data);
		logic [XLEN-1:0] exp_addr;
		logic [XLEN-1:0] exp_data;
		store_count++;
		// A write strobe is only valid together with the enable
		assert (en == 1'b1) else begin
			$display("CHECK FAILED at time %0t: dmem_req.en = %0b, expected 1",
				$time, en);
			error_count++;
		end
		assert (exp_addr_q.size() != 0) else begin
			$display("ERROR at time %0t: unexpected store of 0x%08h to word 0x%08h",
				$time, data, addr);
			error_count++;
		end
		if (exp_addr_q.size() != 0) begin
			exp_addr = exp_addr_q.pop_front();
			exp_data = exp_data_q.pop_front();
			assert (addr == exp_addr) else begin
				$display("CHECK FAILED at time %0t: dmem_req.addr = 0x%08h, expected 0x%08h",
					$time, addr, exp_addr);
				error_count++;
			end
			assert (data == exp_data) else begin
				$display("CHECK FAILED at time %0t: dmem_req.wdata = 0x%08h, expected 0x%08h",
					$time, data, exp_data);
				error_count++;
			end
		end
		if (addr == END_ADDR)
			end_seen = 1'b1;
	endtask

	task automatic report_summary();
		if (exp_addr_q.size() != 0) begin
			$display("ERROR: program ended with %0d expected stores never seen",
				exp_addr_q.size());
			error_count++;
		end
		$display("Stores seen: %0d, errors: %0d", store_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Every write strobe is checked at the edge where memory commits it
	always @(posedge clk) begin
		if (dmem_req.wr)
			check_store(dmem_req.en, dmem_req.addr, dmem_req.wdata);
	end

	initial begin
		bit ok;
		rst_n       = 1'b0;
		prog_len    = 0;
		error_count = 0;
		store_count = 0;
		loaded      = 1'b0;
		end_seen    = 1'b0;
		// Memory model fills its arrays at time zero first
		#1;
		load_stimulus(ok);
		if (!ok) begin
			$display("ERROR: stimulus file %s missing or without program and stores",
				STIM_FILE);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clk);
			#1 rst_n = 1'b1;
			wait (end_seen);
			@(posedge clk);
			report_summary();
		end
	end

	// Watchdog allows eight cycles per program word plus margin
	initial begin
		wait (loaded);
		repeat (prog_len * 8 + 100 + RESET_CYCLES) @(posedge clk);
		$display("ERROR: watchdog expired before the end-marker store was seen");
		if (exp_addr_q.size() != 0)
			$display("ERROR: %0d expected stores were still unchecked", exp_addr_q.size());
		error_count++;
		$display("Stores seen: %0d, errors: %0d", store_count, error_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
